// ==== design/cache_settings.svh ====
/*
 * Geometry macros for the tag side of the set-associative cache
 * Line count, way count, address width and line offset bits
 */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Number of lines held in each way
`define CACHE_LINES 64

// Number of ways per line
// The round-robin victim counter wraps at this count
`define CACHE_WAYS 4

// Width of both virtual and physical addresses
`define CACHE_ADDR_W 32

// Lowest address bit that takes part in the line index
// Six offset bits give a 64-byte line
`define CACHE_LOBIT 6

// Index runs from CACHE_LOBIT upward over log2(CACHE_LINES) bits
// One more bit above the index is left out of the tag (the odd/even line bit)
// The tag takes everything above that bit

`endif

// ==== design/cache_pkg.sv ====
/*
 * Shared types for the cache tag block
 * Address, tag, index and way types, register offsets and address split helpers
 */
`include "cache_settings.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_W-1:0] cache_addr_t;
	typedef logic [$clog2(`CACHE_LINES)-1:0] cache_index_t;
	typedef logic [$clog2(`CACHE_WAYS)-1:0] cache_way_t;

	// Tag sits above the index with one unused bit in between (bits 31 to 13)
	typedef logic [`CACHE_ADDR_W-`CACHE_LOBIT-$clog2(`CACHE_LINES)-2:0] cache_tag_t;

	// AXI4-Lite register address and data
	typedef logic [7:0] cache_reg_addr_t;
	typedef logic [31:0] cache_data_t;

	typedef enum cache_reg_addr_t {
		REG_CTRL   = 8'h00,
		REG_HITS   = 8'h04,
		REG_MISSES = 8'h08,
		REG_INFO   = 8'h0C
	} cache_reg_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} cache_resp_e;

	// Line index from an address
	function automatic cache_index_t addr_index(cache_addr_t a);
		return a[`CACHE_LOBIT +: $bits(cache_index_t)];
	endfunction

	// Tag from the top of an address
	function automatic cache_tag_t addr_tag(cache_addr_t a);
		return a[`CACHE_ADDR_W-1 -: $bits(cache_tag_t)];
	endfunction

endpackage

// ==== design/cache_tag_if.sv ====
/*
 * Tag store access bundle between lookup logic and tag arrays
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

interface cache_tag_if;

	// Read side returns every way of one line in the same cycle
	cache_pkg::cache_index_t rd_index;
	cache_pkg::cache_tag_t [`CACHE_WAYS-1:0] rd_vtag;
	cache_pkg::cache_tag_t [`CACHE_WAYS-1:0] rd_ptag;
	logic [`CACHE_WAYS-1:0] rd_valid;

	// Write side fills one way of one line per clock
	logic wr_en;
	cache_pkg::cache_way_t wr_way;
	cache_pkg::cache_index_t wr_index;
	cache_pkg::cache_tag_t wr_vtag;
	cache_pkg::cache_tag_t wr_ptag;

	// Invalidate every line, takes priority over a write in the same cycle
	logic flush;

	modport lookup (
		output rd_index, wr_en, wr_way, wr_index, wr_vtag, wr_ptag, flush,
		input rd_vtag, rd_ptag, rd_valid
	);

	modport store (
		input rd_index, wr_en, wr_way, wr_index, wr_vtag, wr_ptag, flush,
		output rd_vtag, rd_ptag, rd_valid
	);

endinterface

// ==== design/cache_tag_store.sv ====
/*
 * Tag arrays for all ways with valid bits
 * One write port and a combinational read of every way of one line
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tag_store (
	input logic clk,
	input logic rst,
	cache_tag_if.store tag_if
);
	import cache_pkg::*;

	// Virtual and physical tags per way and line
	// Kept without reset so that they map onto distributed LUT memory
	cache_tag_t vtags [`CACHE_WAYS][`CACHE_LINES];
	cache_tag_t ptags [`CACHE_WAYS][`CACHE_LINES];

	// Valid bits live in flops since flush has to clear them all at once
	logic [`CACHE_WAYS-1:0][`CACHE_LINES-1:0] valid;

	// ======================================================================
	// Write port
	// ======================================================================

	// Both tags of a way are written together from the fill
	// The index comes from the virtual address on the lookup side
	always_ff @(posedge clk) begin
		if (tag_if.wr_en) begin
			vtags[tag_if.wr_way][tag_if.wr_index] <= tag_if.wr_vtag;
			ptags[tag_if.wr_way][tag_if.wr_index] <= tag_if.wr_ptag;
		end
	end

	// Flush beats a write landing in the same cycle
	// so the freshly written way is left invalid too
	always_ff @(posedge clk) begin
		if (rst || tag_if.flush) begin
			valid <= '0;
		end else if (tag_if.wr_en) begin
			valid[tag_if.wr_way][tag_if.wr_index] <= 1'b1;
		end
	end

	// ======================================================================
	// Read port
	// ======================================================================

	// All ways of the addressed line appear in the same cycle
	// The lookup compares them and registers the result itself
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			tag_if.rd_vtag[w] = vtags[w][tag_if.rd_index];
			tag_if.rd_ptag[w] = ptags[w][tag_if.rd_index];
			tag_if.rd_valid[w] = valid[w][tag_if.rd_index];
		end
	end

	// A write and a read of the same line in one cycle
	// return the old contents, the new tags show from the next cycle on

endmodule

// ==== design/cache_victim_select.sv ====
/*
 * Round-robin replacement counters, one per cache line
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_victim_select (
	input logic clk,
	input logic rst,
	input cache_pkg::cache_index_t index_i,
	input logic advance_i,
	output cache_pkg::cache_way_t victim_way_o
);
	import cache_pkg::*;

	// Next way to replace for each line
	cache_way_t rr_q [`CACHE_LINES];

	// The counter of the addressed line is visible without delay
	// so a fill can write into the way shown in the same cycle
	assign victim_way_o = rr_q[index_i];

	// Each advance moves the line on to the following way
	// and the counter wraps from the last way back to way 0
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CACHE_LINES; i++) begin
				rr_q[i] <= '0;
			end
		end else if (advance_i) begin
			rr_q[index_i] <= cache_way_t'(rr_q[index_i] + 1'b1);
		end
	end

	// Flush leaves these counters alone
	// victims carry on from where they stood before the flush

endmodule

// ==== design/cache_lookup.sv ====
/*
 * Tag compare with registered result, fill issue into the victim way
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_lookup (
	input logic clk,
	input logic rst,
	cache_tag_if.lookup tag_if,
	input logic lookup_valid_i,
	input cache_pkg::cache_addr_t lookup_vadr_i,
	input logic fill_valid_i,
	input cache_pkg::cache_addr_t fill_vadr_i,
	input cache_pkg::cache_addr_t fill_padr_i,
	input logic enable_i,
	input logic flush_i,
	output cache_pkg::cache_index_t victim_index_o,
	input cache_pkg::cache_way_t victim_way_i,
	output logic victim_advance_o,
	output logic result_valid_o,
	output logic hit_o,
	output cache_pkg::cache_way_t hit_way_o,
	output cache_pkg::cache_way_t victim_way_o,
	output cache_pkg::cache_tag_t ptag_o
);
	import cache_pkg::*;

	cache_index_t fill_index;
	cache_tag_t lk_tag;
	logic [`CACHE_WAYS-1:0] match;
	logic any_hit;
	cache_way_t match_way;
	cache_tag_t match_ptag;
	logic result_valid_q;
	logic hit_q;
	cache_way_t hit_way_q;
	cache_way_t victim_q;
	cache_tag_t ptag_q;

	assign fill_index = addr_index(fill_vadr_i);
	assign lk_tag = addr_tag(lookup_vadr_i);

	// A fill owns the victim port when present, otherwise the lookup line does
	assign victim_index_o = fill_valid_i ? fill_index : addr_index(lookup_vadr_i);
	assign victim_advance_o = fill_valid_i;

	// Fill goes into the line's current victim and still writes when disabled
	assign tag_if.rd_index = addr_index(lookup_vadr_i);
	assign tag_if.wr_en = fill_valid_i;
	assign tag_if.wr_way = victim_way_i;
	assign tag_if.wr_index = fill_index;
	assign tag_if.wr_vtag = addr_tag(fill_vadr_i);
	assign tag_if.wr_ptag = addr_tag(fill_padr_i);
	assign tag_if.flush = flush_i;

	// Compare against every valid way, a disabled cache reports a miss
	always_comb begin
		match_way = '0;
		match_ptag = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			match[w] = tag_if.rd_valid[w] && (tag_if.rd_vtag[w] == lk_tag);
			if (match[w]) begin
				match_way = cache_way_t'(w);
				match_ptag = tag_if.rd_ptag[w];
			end
		end
		any_hit = enable_i && (|match);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid_q <= 1'b0;
		end else begin
			result_valid_q <= lookup_valid_i;
		end
	end

	// Result payload, way and physical tag read as zero on a miss
	always_ff @(posedge clk) begin
		if (lookup_valid_i) begin
			hit_q <= any_hit;
			hit_way_q <= any_hit ? match_way : '0;
			ptag_q <= any_hit ? match_ptag : '0;
			victim_q <= victim_way_i;
		end
	end

	assign result_valid_o = result_valid_q;
	assign hit_o = hit_q;
	assign hit_way_o = hit_way_q;
	assign ptag_o = ptag_q;
	assign victim_way_o = victim_q;

endmodule

// ==== design/cache_ctrl_regs.sv ====
/*
 * AXI4-Lite register block with enable, flush, hit and miss counters
 * and the read-only geometry word
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl_regs (
	input logic clk,
	input logic rst,
	input logic awvalid_i,
	output logic awready_o,
	input cache_pkg::cache_reg_addr_t awaddr_i,
	input logic wvalid_i,
	output logic wready_o,
	input cache_pkg::cache_data_t wdata_i,
	output logic bvalid_o,
	input logic bready_i,
	output cache_pkg::cache_resp_e bresp_o,
	input logic arvalid_i,
	output logic arready_o,
	input cache_pkg::cache_reg_addr_t araddr_i,
	output logic rvalid_o,
	input logic rready_i,
	output cache_pkg::cache_data_t rdata_o,
	output cache_pkg::cache_resp_e rresp_o,
	output logic enable_o,
	output logic flush_o,
	input logic result_valid_i,
	input logic hit_i
);
	import cache_pkg::*;

	logic aw_ready_q;
	logic wr_accept;
	logic wr_ok;
	logic clr_hits;
	logic clr_misses;
	logic bvalid_q;
	cache_resp_e bresp_q;
	logic rd_accept;
	logic rvalid_q;
	cache_data_t rd_data;
	cache_resp_e rd_resp;
	cache_data_t rdata_q;
	cache_resp_e rresp_q;
	logic enable_q;
	logic enable_d;
	logic flush_q;
	cache_data_t hits_q;
	cache_data_t misses_q;

	// ======================================================================
	// Write channel
	// ======================================================================

	// Address and data are taken together in the single ready cycle
	assign wr_accept = aw_ready_q && awvalid_i && wvalid_i;

	always_comb begin
		wr_ok = 1'b1;
		clr_hits = 1'b0;
		clr_misses = 1'b0;
		case (awaddr_i)
			REG_CTRL: ;
			REG_HITS: clr_hits = 1'b1;
			REG_MISSES: clr_misses = 1'b1;
			default: wr_ok = 1'b0;
		endcase
	end

	// Ready rises for one cycle only while no write response is waiting
	// Flush pulses in the cycle after the REG_CTRL write is accepted
	always_ff @(posedge clk) begin
		if (rst) begin
			aw_ready_q <= 1'b0;
			bvalid_q <= 1'b0;
			enable_q <= 1'b0;
			flush_q <= 1'b0;
		end else begin
			aw_ready_q <= awvalid_i && wvalid_i && !bvalid_q && !aw_ready_q;
			flush_q <= 1'b0;
			if (wr_accept) begin
				bvalid_q <= 1'b1;
				if (awaddr_i == REG_CTRL) begin
					enable_q <= wdata_i[0];
					flush_q <= wdata_i[1];
				end
			end else if (bvalid_q && bready_i) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ======================================================================
	// Hit and miss counters
	// ======================================================================

	// A result leaves the lookup one cycle after its request, so the
	// enable it saw is the one delayed by a cycle here
	always_ff @(posedge clk) begin
		if (rst) begin
			enable_d <= 1'b0;
			hits_q <= '0;
			misses_q <= '0;
		end else begin
			enable_d <= enable_q;
			if (wr_accept && clr_hits) begin
				hits_q <= '0;
			end else if (result_valid_i && enable_d && hit_i) begin
				hits_q <= hits_q + 1'b1;
			end
			if (wr_accept && clr_misses) begin
				misses_q <= '0;
			end else if (result_valid_i && enable_d && !hit_i) begin
				misses_q <= misses_q + 1'b1;
			end
		end
	end

	// ======================================================================
	// Read channel
	// ======================================================================

	assign rd_accept = arvalid_i && !rvalid_q;

	always_comb begin
		rd_resp = RESP_OKAY;
		case (araddr_i)
			REG_CTRL: rd_data = {31'b0, enable_q};
			REG_HITS: rd_data = hits_q;
			REG_MISSES: rd_data = misses_q;
			REG_INFO: rd_data = {16'(`CACHE_WAYS), 16'(`CACHE_LINES)};
			default: begin
				rd_data = '0;
				rd_resp = RESP_SLVERR;
			end
		endcase
	end

	// Response waits in place until the master takes it
	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid_q <= 1'b0;
		end else if (rd_accept) begin
			rvalid_q <= 1'b1;
		end else if (rready_i) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rdata_q <= rd_data;
			rresp_q <= rd_resp;
		end
	end

	assign awready_o = aw_ready_q;
	assign wready_o = aw_ready_q;
	assign bvalid_o = bvalid_q;
	assign bresp_o = bresp_q;
	assign arready_o = !rvalid_q;
	assign rvalid_o = rvalid_q;
	assign rdata_o = rdata_q;
	assign rresp_o = rresp_q;
	assign enable_o = enable_q;
	assign flush_o = flush_q;

endmodule

// ==== design/cache_tag_top.sv ====
/*
 * Top level of the cache tag block
 * Joins tag store, victim counters, lookup and register block
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tag_top (
	input logic clk,
	input logic rst,
	input logic lookup_valid_i,
	input cache_pkg::cache_addr_t lookup_vadr_i,
	input logic fill_valid_i,
	input cache_pkg::cache_addr_t fill_vadr_i,
	input cache_pkg::cache_addr_t fill_padr_i,
	output logic result_valid_o,
	output logic hit_o,
	output cache_pkg::cache_way_t hit_way_o,
	output cache_pkg::cache_way_t victim_way_o,
	output cache_pkg::cache_tag_t ptag_o,
	input logic awvalid_i,
	output logic awready_o,
	input cache_pkg::cache_reg_addr_t awaddr_i,
	input logic wvalid_i,
	output logic wready_o,
	input cache_pkg::cache_data_t wdata_i,
	output logic bvalid_o,
	input logic bready_i,
	output cache_pkg::cache_resp_e bresp_o,
	input logic arvalid_i,
	output logic arready_o,
	input cache_pkg::cache_reg_addr_t araddr_i,
	output logic rvalid_o,
	input logic rready_i,
	output cache_pkg::cache_data_t rdata_o,
	output cache_pkg::cache_resp_e rresp_o
);
	import cache_pkg::*;

	cache_index_t victim_index;
	cache_way_t victim_way;
	logic victim_advance;
	logic enable;
	logic flush;

	cache_tag_if tag_if ();

	cache_tag_store u_store (
		.clk, .rst,
		.tag_if(tag_if.store)
	);

	cache_victim_select u_victim (
		.clk, .rst,
		.index_i(victim_index),
		.advance_i(victim_advance),
		.victim_way_o(victim_way)
	);

	// The registered result also feeds the counters in the register block
	cache_lookup u_lookup (
		.clk, .rst,
		.tag_if(tag_if.lookup),
		.lookup_valid_i, .lookup_vadr_i,
		.fill_valid_i, .fill_vadr_i, .fill_padr_i,
		.enable_i(enable), .flush_i(flush),
		.victim_index_o(victim_index), .victim_way_i(victim_way),
		.victim_advance_o(victim_advance),
		.result_valid_o, .hit_o, .hit_way_o, .victim_way_o, .ptag_o
	);

	cache_ctrl_regs u_regs (
		.clk, .rst,
		.awvalid_i, .awready_o, .awaddr_i,
		.wvalid_i, .wready_o, .wdata_i,
		.bvalid_o, .bready_i, .bresp_o,
		.arvalid_i, .arready_o, .araddr_i,
		.rvalid_o, .rready_i, .rdata_o, .rresp_o,
		.enable_o(enable), .flush_o(flush),
		.result_valid_i(result_valid_o), .hit_i(hit_o)
	);

endmodule

// ==== test/cache_tag_tb.sv ====
/*
 * Testbench for the cache tag block with a reference model, a result checker
 * and AXI4-Lite access tasks
 */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tag_tb;
	import cache_pkg::*;

	// Expected result of one lookup as the model predicts it
	typedef struct packed {
		logic hit;
		cache_way_t way;
		cache_way_t victim;
		cache_tag_t ptag;
	} result_t;

	logic clk;
	logic rst;
	logic lookup_valid;
	cache_addr_t lookup_vadr;
	logic fill_valid;
	cache_addr_t fill_vadr;
	cache_addr_t fill_padr;
	logic result_valid;
	logic hit;
	cache_way_t hit_way;
	cache_way_t victim_way;
	cache_tag_t ptag;
	logic awvalid;
	logic awready;
	cache_reg_addr_t awaddr;
	logic wvalid;
	logic wready;
	cache_data_t wdata;
	logic bvalid;
	logic bready;
	cache_resp_e bresp;
	logic arvalid;
	logic arready;
	cache_reg_addr_t araddr;
	logic rvalid;
	logic rready;
	cache_data_t rdata;
	cache_resp_e rresp;

	// Reference model state with tags, valid bits, round-robin counters and counts
	cache_tag_t m_vtag [`CACHE_WAYS][`CACHE_LINES];
	cache_tag_t m_ptag [`CACHE_WAYS][`CACHE_LINES];
	logic m_valid [`CACHE_WAYS][`CACHE_LINES];
	cache_way_t m_rr [`CACHE_LINES];
	logic m_enable;
	int m_hits;
	int m_misses;
	cache_tag_t next_tag;
	result_t exp_q [$];

	// Lookup request as the DUT saw it at the last rising edge
	logic lookup_sampled;

	cache_tag_top DUT (
		.clk, .rst,
		.lookup_valid_i(lookup_valid), .lookup_vadr_i(lookup_vadr),
		.fill_valid_i(fill_valid), .fill_vadr_i(fill_vadr), .fill_padr_i(fill_padr),
		.result_valid_o(result_valid), .hit_o(hit), .hit_way_o(hit_way),
		.victim_way_o(victim_way), .ptag_o(ptag),
		.awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
		.wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata),
		.bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
		.arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
		.rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp)
	);

	always #10 clk = ~clk;

	// ======================================================================
	// Checking and failure reporting
	// ======================================================================

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================

	// Hit on a valid way whose virtual tag matches and miss whenever disabled
	function automatic result_t expect_lookup(cache_index_t idx, cache_tag_t tag);
		result_t r;
		r = '0;
		r.victim = m_rr[idx];
		if (m_enable) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (m_valid[w][idx] && m_vtag[w][idx] == tag) begin
					r.hit = 1'b1;
					r.way = cache_way_t'(w);
					r.ptag = m_ptag[w][idx];
				end
			end
		end
		return r;
	endfunction

	// Tag goes in bits 31:13 while bit 12 and the line offset get random values
	function automatic cache_addr_t make_addr(cache_tag_t tag, cache_index_t idx);
		logic [6:0] junk;
		junk = 7'($urandom);
		return {tag, junk[6], idx, junk[5:0]};
	endfunction

	// One cycle of lookup and fill where the lookup sees the state before the fill
	task automatic issue(input logic do_lookup, input cache_index_t l_idx,
		input cache_tag_t l_tag, input logic do_fill, input cache_index_t f_idx,
		input cache_tag_t f_vtag, input cache_tag_t f_ptag);
		result_t r;
		cache_way_t w;
		lookup_valid = do_lookup;
		lookup_vadr = make_addr(l_tag, l_idx);
		fill_valid = do_fill;
		fill_vadr = make_addr(f_vtag, f_idx);
		fill_padr = make_addr(f_ptag, cache_index_t'($urandom));
		if (do_lookup) begin
			r = expect_lookup(l_idx, l_tag);
			exp_q.push_back(r);
			if (m_enable && r.hit) begin
				m_hits++;
			end else if (m_enable) begin
				m_misses++;
			end
		end
		if (do_fill) begin
			w = m_rr[f_idx];
			m_vtag[w][f_idx] = f_vtag;
			m_ptag[w][f_idx] = f_ptag;
			m_valid[w][f_idx] = 1'b1;
			m_rr[f_idx] = cache_way_t'(w + 2'd1);
		end
		next_cycle();
	endtask

	task automatic drain_results();
		int n;
		lookup_valid = 1'b0;
		fill_valid = 1'b0;
		n = 0;
		while (exp_q.size() != 0) begin
			next_cycle();
			n++;
			if (n > 20) stop_with_failure("Timeout waiting for outstanding lookup results");
		end
	endtask

	// Lookups and fills on lines 0 to 15 where a fill beside a lookup uses the lookup's line
	task automatic random_mix(input int cycles);
		int kind;
		cache_index_t l_idx;
		cache_index_t f_idx;
		cache_tag_t l_tag;
		cache_way_t w;
		for (int i = 0; i < cycles; i++) begin
			kind = int'($urandom % 4);
			l_idx = cache_index_t'($urandom % 16);
			f_idx = (kind == 2) ? l_idx : cache_index_t'($urandom % 16);
			w = cache_way_t'($urandom);
			l_tag = ($urandom % 2 == 0) ? m_vtag[w][l_idx] : cache_tag_t'($urandom);
			issue(kind != 1, l_idx, l_tag, kind == 1 || kind == 2, f_idx, next_tag,
				cache_tag_t'($urandom));
			if (kind == 1 || kind == 2) begin
				next_tag++;
			end
		end
		drain_results();
	endtask

	always @(posedge clk) begin
		lookup_sampled <= lookup_valid;
	end

	// Results are sampled mid-cycle where they are stable
	// A result shows in exactly the cycle after its lookup was taken
	always @(negedge clk) begin
		result_t e;
		if (!rst) begin
			check("result_valid_o", result_valid, lookup_sampled);
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					stop_with_failure("A result appeared with no lookup outstanding");
				end else begin
					e = exp_q.pop_front();
					check("hit_o", hit, e.hit);
					check("hit_way_o", hit_way, e.way);
					check("victim_way_o", victim_way, e.victim);
					check("ptag_o", ptag, e.ptag);
				end
			end
		end
	end

	// ======================================================================
	// AXI4-Lite access
	// ======================================================================

	task automatic axi_write(input cache_reg_addr_t addr, input cache_data_t data,
		output cache_resp_e resp);
		int n;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while (!awready) begin
			next_cycle();
			n++;
			if (n > 20) stop_with_failure("Timeout waiting for awready");
		end
		check("wready_o", wready, 1);
		next_cycle();
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		n = 0;
		while (!bvalid) begin
			next_cycle();
			n++;
			if (n > 20) stop_with_failure("Timeout waiting for bvalid");
		end
		resp = bresp;
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic axi_read(input cache_reg_addr_t addr, output cache_data_t data,
		output cache_resp_e resp);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready) begin
			next_cycle();
			n++;
			if (n > 20) stop_with_failure("Timeout waiting for arready");
		end
		next_cycle();
		arvalid = 1'b0;
		rready = 1'b1;
		n = 0;
		while (!rvalid) begin
			next_cycle();
			n++;
			if (n > 20) stop_with_failure("Timeout waiting for rvalid");
		end
		data = rdata;
		resp = rresp;
		next_cycle();
		rready = 1'b0;
	endtask

	task automatic write_expect(input cache_reg_addr_t addr, input cache_data_t data,
		input cache_resp_e exp_resp);
		cache_resp_e resp;
		axi_write(addr, data, resp);
		check("bresp_o", resp, exp_resp);
	endtask

	// Read data is only defined for an OKAY response
	task automatic read_expect(input string name, input cache_reg_addr_t addr,
		input cache_data_t exp_data, input cache_resp_e exp_resp);
		cache_data_t data;
		cache_resp_e resp;
		axi_read(addr, data, resp);
		check("rresp_o", resp, exp_resp);
		if (exp_resp == RESP_OKAY) begin
			check(name, data, exp_data);
		end
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		cache_tag_t t [5];
		void'($urandom(83));
		clk = 1'b0;
		rst = 1'b1;
		lookup_valid = 1'b0;
		lookup_vadr = '0;
		fill_valid = 1'b0;
		fill_vadr = '0;
		fill_padr = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		for (int l = 0; l < `CACHE_LINES; l++) begin
			m_rr[l] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				m_vtag[w][l] = '0;
				m_ptag[w][l] = '0;
				m_valid[w][l] = 1'b0;
			end
		end
		m_enable = 1'b0;
		m_hits = 0;
		m_misses = 0;
		next_tag = cache_tag_t'(19'h100);
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// Handshake outputs and registers straight after reset
		check("result_valid_o", result_valid, 0);
		check("bvalid_o", bvalid, 0);
		check("rvalid_o", rvalid, 0);
		check("awready_o", awready, 0);
		check("wready_o", wready, 0);
		check("arready_o", arready, 1);
		read_expect("REG_CTRL", REG_CTRL, 32'h0, RESP_OKAY);
		read_expect("REG_INFO", REG_INFO, {16'd4, 16'd64}, RESP_OKAY);
		read_expect("REG_HITS", REG_HITS, 32'h0, RESP_OKAY);
		read_expect("REG_MISSES", REG_MISSES, 32'h0, RESP_OKAY);
		write_expect(REG_INFO, 32'h1234, RESP_SLVERR);
		read_expect("unused offset", 8'h10, 32'h0, RESP_SLVERR);

		// Disabled cache misses everywhere with victim 0 and counts nothing
		// Four fills still land in line 9 and bring its counter round to 0 again
		for (int i = 0; i < 4; i++) begin
			t[i] = next_tag;
			next_tag++;
			issue(1'b0, '0, '0, 1'b1, 6'd9, t[i], cache_tag_t'($urandom));
		end
		for (int i = 0; i < 4; i++) begin
			issue(1'b1, 6'd9, t[i], 1'b0, '0, '0, '0);
		end
		for (int i = 0; i < 8; i++) begin
			issue(1'b1, cache_index_t'($urandom), cache_tag_t'($urandom), 1'b0, '0, '0, '0);
		end
		drain_results();
		read_expect("REG_MISSES", REG_MISSES, 32'h0, RESP_OKAY);

		write_expect(REG_CTRL, 32'h1, RESP_OKAY);
		m_enable = 1'b1;
		read_expect("REG_CTRL", REG_CTRL, 32'h1, RESP_OKAY);

		// Tags filled while disabled hit once the cache is enabled
		for (int i = 0; i < 4; i++) begin
			issue(1'b1, 6'd9, t[i], 1'b0, '0, '0, '0);
		end

		// Five fills to line 5 rotate through ways 0 to 3 and back to 0
		for (int i = 0; i < 5; i++) begin
			t[i] = next_tag;
			next_tag++;
			issue(1'b0, '0, '0, 1'b1, 6'd5, t[i], cache_tag_t'($urandom));
		end
		for (int i = 1; i < 5; i++) begin
			issue(1'b1, 6'd5, t[i], 1'b0, '0, '0, '0);
		end
		issue(1'b1, 6'd5, t[0], 1'b0, '0, '0, '0);
		drain_results();

		random_mix(300);
		read_expect("REG_HITS", REG_HITS, m_hits, RESP_OKAY);
		read_expect("REG_MISSES", REG_MISSES, m_misses, RESP_OKAY);
		write_expect(REG_HITS, 32'h0, RESP_OKAY);
		write_expect(REG_MISSES, 32'h0, RESP_OKAY);
		m_hits = 0;
		m_misses = 0;
		read_expect("REG_HITS", REG_HITS, 32'h0, RESP_OKAY);
		read_expect("REG_MISSES", REG_MISSES, 32'h0, RESP_OKAY);

		// Flush with enable kept while the victim counters survive it
		write_expect(REG_CTRL, 32'h3, RESP_OKAY);
		for (int l = 0; l < `CACHE_LINES; l++) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				m_valid[w][l] = 1'b0;
			end
		end
		read_expect("REG_CTRL", REG_CTRL, 32'h1, RESP_OKAY);
		for (int l = 0; l < 16; l++) begin
			issue(1'b1, cache_index_t'(l), m_vtag[l % 4][l], 1'b0, '0, '0, '0);
		end
		drain_results();
		random_mix(100);
		read_expect("REG_HITS", REG_HITS, m_hits, RESP_OKAY);
		read_expect("REG_MISSES", REG_MISSES, m_misses, RESP_OKAY);

		$display("No errors");
		$finish;
	end

	// Upper bound on the whole run
	initial begin
		#1ms;
		stop_with_failure("The run exceeded its time limit");
	end

endmodule

// ==== tb.f ====
+incdir+design
design/cache_pkg.sv
design/cache_tag_if.sv
design/cache_tag_store.sv
design/cache_victim_select.sv
design/cache_lookup.sv
design/cache_ctrl_regs.sv
design/cache_tag_top.sv
test/cache_tag_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cache tag testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module cache_tag_tb \
	-o cache_tag_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/cache_tag_sim > sim.log 2>&1

grep -q "Errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
